// ==== project.f ====
src/csr_addr_pkg.sv
src/csr_field_pkg.sv
src/csr_write_if.sv
src/csr_exc_regs.sv
src/csr_timer.sv
src/csr_int_ctrl.sv
src/csr_read_mux.sv
src/csr_top.sv
testbench/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module csr_tb -o csr_sim

out=$(./obj_dir/csr_sim)
echo "$out"

# a missing pass line makes grep, and so the script, fail
echo "$out" | grep -q "TEST RESULT: PASS"

// ==== testbench/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;

    typedef enum {OP_WRITE, OP_READ, OP_EXC, OP_ERTN, OP_WAIT, OP_INT, OP_ENTRY, OP_RETADDR} op_t;

    typedef struct {
        op_t                    op;
        int                     test;
        csr_addr_pkg::csr_num_t num;
        csr_field_pkg::word_t   mask;
        csr_field_pkg::word_t   value;
        int                     wait_cycles;
        csr_field_pkg::word_t   expected;
    } step_t;

    localparam int NUM_TESTS = 5;
    localparam csr_field_pkg::word_t ALL = 32'hffff_ffff;

    // exception used in the entry and return test
    localparam csr_field_pkg::word_t    EXC_PC    = 32'h1c00_1234;
    localparam csr_addr_pkg::ecode_t    EXC_ECODE = 6'h0b;
    localparam csr_addr_pkg::esubcode_t EXC_ESUB  = 9'h001;

    localparam int TIMER_N = 3;

    logic                    clk;
    logic                    rst;
    logic                    we;
    csr_addr_pkg::csr_num_t  wnum;
    csr_field_pkg::word_t    wmask;
    csr_field_pkg::word_t    wval;
    csr_addr_pkg::csr_num_t  rnum;
    csr_field_pkg::word_t    rval;
    logic                    wb_exc;
    csr_addr_pkg::ecode_t    wb_ecode;
    csr_addr_pkg::esubcode_t wb_esubcode;
    csr_field_pkg::word_t    wb_pc;
    logic                    ertn_flush;
    logic                    has_int;
    csr_field_pkg::word_t    exc_entry;
    csr_field_pkg::word_t    exc_retaddr;

    step_t steps[$];
    string test_names[NUM_TESTS];
    int    test_errors[NUM_TESTS];
    int    test_checks[NUM_TESTS];
    int    errors;
    int    checks;
    int    cycles;
    int    cycle_limit;

    csr_top i_csr_top (
        .clk         (clk),
        .rst         (rst),
        .we          (we),
        .wnum        (wnum),
        .wmask       (wmask),
        .wval        (wval),
        .rnum        (rnum),
        .rval        (rval),
        .wb_exc      (wb_exc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .has_int     (has_int),
        .exc_entry   (exc_entry),
        .exc_retaddr (exc_retaddr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // new bit where mask is one, old bit elsewhere
    function automatic csr_field_pkg::word_t merge(csr_field_pkg::word_t old_val,
                                                   csr_field_pkg::word_t mask,
                                                   csr_field_pkg::word_t new_val);
        return (mask & new_val) | (~mask & old_val);
    endfunction

    task automatic add_step(op_t op, int test, csr_addr_pkg::csr_num_t num,
                            csr_field_pkg::word_t mask, csr_field_pkg::word_t value,
                            int wait_cycles, csr_field_pkg::word_t expected);
        step_t s;
        s.op          = op;
        s.test        = test;
        s.num         = num;
        s.mask        = mask;
        s.value       = value;
        s.wait_cycles = wait_cycles;
        s.expected    = expected;
        steps.push_back(s);
    endtask

    task automatic build_table();
        csr_field_pkg::word_t save0;
        csr_field_pkg::word_t entry;
        csr_field_pkg::word_t estat_code;
        csr_field_pkg::word_t tcfg_val;
        csr_field_pkg::word_t tval_load;
        save0      = merge(32'h0, ALL, 32'h1234_5678);
        entry      = 32'h1c00_807f & ~((32'h1 << csr_field_pkg::ENTRY_ALIGN) - 32'h1);
        estat_code = {1'b0, EXC_ESUB, EXC_ECODE, 16'h0};
        tcfg_val   = {30'(TIMER_N), 1'b0, 1'b1};
        tval_load  = 32'(TIMER_N) << csr_field_pkg::TIMER_SHIFT;

        add_step(OP_READ, 0, csr_addr_pkg::CSR_CRMD, ALL, 0, 0, 32'h0);
        add_step(OP_READ, 0, csr_addr_pkg::CSR_PRMD, ALL, 0, 0, 32'h0);
        add_step(OP_READ, 0, csr_addr_pkg::CSR_ECFG, ALL, 0, 0, 32'h0);
        add_step(OP_READ, 0, csr_addr_pkg::CSR_ESTAT, ALL, 0, 0, 32'h0);
        add_step(OP_READ, 0, csr_addr_pkg::CSR_ERA, ALL, 0, 0, 32'h0);
        add_step(OP_READ, 0, csr_addr_pkg::CSR_TVAL, ALL, 0, 0, csr_field_pkg::TIMER_IDLE);
        add_step(OP_INT, 0, 0, ALL, 0, 0, 32'h0);
        add_step(OP_ENTRY, 0, 0, ALL, 0, 0, 32'h0);
        add_step(OP_RETADDR, 0, 0, ALL, 0, 0, 32'h0);

        add_step(OP_WRITE, 1, csr_addr_pkg::CSR_SAVE0, ALL, 32'h1234_5678, 0, 0);
        add_step(OP_READ, 1, csr_addr_pkg::CSR_SAVE0, ALL, 0, 0, save0);
        add_step(OP_WRITE, 1, csr_addr_pkg::CSR_SAVE0, 32'hffff_0000, 32'habcd_ef01, 0, 0);
        add_step(OP_READ, 1, csr_addr_pkg::CSR_SAVE0, ALL, 0, 0,
                 merge(save0, 32'hffff_0000, 32'habcd_ef01));
        add_step(OP_WRITE, 1, csr_addr_pkg::CSR_SAVE3, ALL, 32'h0bad_f00d, 0, 0);
        add_step(OP_READ, 1, csr_addr_pkg::CSR_SAVE3, ALL, 0, 0, 32'h0bad_f00d);
        add_step(OP_WRITE, 1, csr_addr_pkg::CSR_EENTRY, ALL, 32'h1c00_807f, 0, 0);
        add_step(OP_READ, 1, csr_addr_pkg::CSR_EENTRY, ALL, 0, 0, entry);
        add_step(OP_ENTRY, 1, 0, ALL, 0, 0, entry);

        // CRMD with PLV 3 and IE set
        add_step(OP_WRITE, 2, csr_addr_pkg::CSR_CRMD, ALL, 32'h7, 0, 0);
        add_step(OP_READ, 2, csr_addr_pkg::CSR_CRMD, ALL, 0, 0, 32'h7);
        // mask column carries {esubcode, ecode} for an exception row
        add_step(OP_EXC, 2, 0, {17'h0, EXC_ESUB, EXC_ECODE}, EXC_PC, 0, 0);
        add_step(OP_READ, 2, csr_addr_pkg::CSR_CRMD, ALL, 0, 0, 32'h0);
        add_step(OP_READ, 2, csr_addr_pkg::CSR_PRMD, ALL, 0, 0, 32'h7);
        add_step(OP_READ, 2, csr_addr_pkg::CSR_ERA, ALL, 0, 0, EXC_PC);
        add_step(OP_RETADDR, 2, 0, ALL, 0, 0, EXC_PC);
        add_step(OP_READ, 2, csr_addr_pkg::CSR_ESTAT, 32'h7fff_0000, 0, 0, estat_code);
        add_step(OP_ERTN, 2, 0, ALL, 0, 0, 0);
        add_step(OP_READ, 2, csr_addr_pkg::CSR_CRMD, ALL, 0, 0, 32'h7);

        add_step(OP_WRITE, 3, csr_addr_pkg::CSR_TCFG, ALL, tcfg_val, 0, 0);
        add_step(OP_READ, 3, csr_addr_pkg::CSR_TVAL, ALL, 0, 0, tval_load);
        add_step(OP_READ, 3, csr_addr_pkg::CSR_TCFG, ALL, 0, 0, tcfg_val);
        // two rows above took two cycles, zero is reached after tval_load
        add_step(OP_WAIT, 3, 0, ALL, 0, int'(tval_load) - 2, 0);
        add_step(OP_READ, 3, csr_addr_pkg::CSR_TVAL, ALL, 0, 0, csr_field_pkg::TIMER_IDLE);
        add_step(OP_READ, 3, csr_addr_pkg::CSR_ESTAT, 32'h1 << csr_field_pkg::TIMER_IRQ, 0, 0,
                 32'h1 << csr_field_pkg::TIMER_IRQ);
        add_step(OP_WRITE, 3, csr_addr_pkg::CSR_TICLR, 32'h1, 32'h1, 0, 0);
        add_step(OP_READ, 3, csr_addr_pkg::CSR_ESTAT, 32'h1 << csr_field_pkg::TIMER_IRQ, 0, 0,
                 32'h0);

        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_ECFG, ALL, 32'h1, 0, 0);
        add_step(OP_INT, 4, 0, ALL, 0, 0, 32'h0);
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_ESTAT, 32'h1, 32'h1, 0, 0);
        add_step(OP_INT, 4, 0, ALL, 0, 0, 32'h1);
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_CRMD, 32'h4, 32'h0, 0, 0);
        add_step(OP_INT, 4, 0, ALL, 0, 0, 32'h0);
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_ESTAT, 32'h1, 32'h0, 0, 0);
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_ECFG, ALL, 32'h1 << csr_field_pkg::TIMER_IRQ, 0, 0);
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_CRMD, 32'h4, 32'h4, 0, 0);
        add_step(OP_INT, 4, 0, ALL, 0, 0, 32'h0);
        // initial value 1 loads as 4, expiry is seen five cycles on
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_TCFG, ALL, {30'd1, 1'b0, 1'b1}, 5, 0);
        add_step(OP_INT, 4, 0, ALL, 0, 0, 32'h1);
        add_step(OP_WRITE, 4, csr_addr_pkg::CSR_CRMD, 32'h4, 32'h0, 0, 0);
        add_step(OP_INT, 4, 0, ALL, 0, 0, 32'h0);
    endtask

    task automatic check_value(string name, csr_field_pkg::word_t actual,
                               csr_field_pkg::word_t expected, int test);
        checks++;
        test_checks[test]++;
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            errors++;
            test_errors[test]++;
        end
    endtask

    // every row starts on a falling edge and takes one cycle plus its wait
    task automatic apply_step(step_t s);
        case (s.op)
            OP_WRITE: begin
                we    = 1'b1;
                wnum  = s.num;
                wmask = s.mask;
                wval  = s.value;
            end
            OP_EXC: begin
                wb_exc      = 1'b1;
                wb_pc       = s.value;
                wb_ecode    = s.mask[5:0];
                wb_esubcode = s.mask[14:6];
            end
            OP_ERTN: ertn_flush = 1'b1;
            OP_READ: rnum = s.num;
            default: ;
        endcase
        #1;
        case (s.op)
            OP_READ: check_value($sformatf("rval[%03h]", s.num), rval & s.mask,
                                 s.expected & s.mask, s.test);
            OP_INT: check_value("has_int", csr_field_pkg::word_t'(has_int), s.expected, s.test);
            OP_ENTRY: check_value("exc_entry", exc_entry, s.expected, s.test);
            OP_RETADDR: check_value("exc_retaddr", exc_retaddr, s.expected, s.test);
            default: ;
        endcase
        @(negedge clk);
        we         = 1'b0;
        wb_exc     = 1'b0;
        ertn_flush = 1'b0;
        repeat (s.wait_cycles) @(negedge clk);
    endtask

    task automatic report_test(int t);
        $display("test %0d %s: %s (%0d checks, %0d errors)", t, test_names[t],
                 test_errors[t] == 0 ? "ok" : "failed", test_checks[t], test_errors[t]);
    endtask

    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int cur;
        int failed_tests;
        int limit;
        rst         = 1'b1;
        we          = 1'b0;
        wnum        = '0;
        wmask       = '0;
        wval        = '0;
        rnum        = '0;
        wb_exc      = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        ertn_flush  = 1'b0;
        errors      = 0;
        checks      = 0;
        cycle_limit = 0;
        test_names[0] = "reset values";
        test_names[1] = "masked writes";
        test_names[2] = "exception entry and return";
        test_names[3] = "timer";
        test_names[4] = "interrupts";
        foreach (test_errors[t]) begin
            test_errors[t] = 0;
            test_checks[t] = 0;
        end

        build_table();
        limit = steps.size() + 100;
        foreach (steps[i]) begin
            limit += steps[i].wait_cycles;
        end
        cycle_limit = limit;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        cur = 0;
        foreach (steps[i]) begin
            if (steps[i].test != cur) begin
                report_test(cur);
                cur = steps[i].test;
            end
            apply_step(steps[i]);
        end
        report_test(cur);

        failed_tests = 0;
        foreach (test_errors[t]) begin
            if (test_errors[t] != 0) begin
                failed_tests++;
            end
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  csr_addr_pkg::csr_num_t   wnum,
    input  csr_field_pkg::word_t     wmask,
    input  csr_field_pkg::word_t     wval,
    input  csr_addr_pkg::csr_num_t   rnum,
    output csr_field_pkg::word_t     rval,
    input  logic                     wb_exc,
    input  csr_addr_pkg::ecode_t     wb_ecode,
    input  csr_addr_pkg::esubcode_t  wb_esubcode,
    input  csr_field_pkg::word_t     wb_pc,
    input  logic                     ertn_flush,
    output logic                     has_int,
    output csr_field_pkg::word_t     exc_entry,
    output csr_field_pkg::word_t     exc_retaddr
);

    csr_write_if wr_bus ();

    logic                              crmd_ie;
    logic                              timer_expire;
    logic [csr_field_pkg::IS_BITS-1:0] estat_is;
    csr_field_pkg::word_t              crmd_rval;
    csr_field_pkg::word_t              prmd_rval;
    csr_field_pkg::word_t              era_rval;
    csr_field_pkg::word_t              eentry_rval;
    csr_field_pkg::word_t              estat_code_rval;
    csr_field_pkg::word_t [3:0]        save_rval;
    csr_field_pkg::word_t              ecfg_rval;
    csr_field_pkg::word_t              tcfg_rval;
    csr_field_pkg::word_t              tval_rval;

    assign wr_bus.we   = we;
    assign wr_bus.num  = wnum;
    assign wr_bus.mask = wmask;
    assign wr_bus.wval = wval;

    csr_exc_regs i_csr_exc_regs (
        .clk             (clk),
        .rst             (rst),
        .wr              (wr_bus.sink),
        .wb_exc          (wb_exc),
        .wb_ecode        (wb_ecode),
        .wb_esubcode     (wb_esubcode),
        .wb_pc           (wb_pc),
        .ertn_flush      (ertn_flush),
        .crmd_ie         (crmd_ie),
        .crmd_rval       (crmd_rval),
        .prmd_rval       (prmd_rval),
        .era_rval        (era_rval),
        .eentry_rval     (eentry_rval),
        .estat_code_rval (estat_code_rval),
        .save_rval       (save_rval)
    );

    csr_timer i_csr_timer (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr_bus.sink),
        .tcfg_rval    (tcfg_rval),
        .tval_rval    (tval_rval),
        .timer_expire (timer_expire)
    );

    csr_int_ctrl i_csr_int_ctrl (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr_bus.sink),
        .crmd_ie      (crmd_ie),
        .timer_expire (timer_expire),
        .ecfg_rval    (ecfg_rval),
        .estat_is     (estat_is),
        .has_int      (has_int)
    );

    csr_read_mux i_csr_read_mux (
        .rnum            (rnum),
        .crmd_rval       (crmd_rval),
        .prmd_rval       (prmd_rval),
        .era_rval        (era_rval),
        .eentry_rval     (eentry_rval),
        .estat_code_rval (estat_code_rval),
        .save_rval       (save_rval),
        .ecfg_rval       (ecfg_rval),
        .tcfg_rval       (tcfg_rval),
        .tval_rval       (tval_rval),
        .estat_is        (estat_is),
        .rval            (rval)
    );

    // handler entry and return address for the fetch stage
    assign exc_entry   = eentry_rval;
    assign exc_retaddr = era_rval;

endmodule

// ==== src/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_addr_pkg::csr_num_t              rnum,
    input  csr_field_pkg::word_t                crmd_rval,
    input  csr_field_pkg::word_t                prmd_rval,
    input  csr_field_pkg::word_t                era_rval,
    input  csr_field_pkg::word_t                eentry_rval,
    input  csr_field_pkg::word_t                estat_code_rval,
    input  csr_field_pkg::word_t [3:0]          save_rval,
    input  csr_field_pkg::word_t                ecfg_rval,
    input  csr_field_pkg::word_t                tcfg_rval,
    input  csr_field_pkg::word_t                tval_rval,
    input  logic [csr_field_pkg::IS_BITS-1:0]   estat_is,
    output csr_field_pkg::word_t                rval
);

    csr_field_pkg::csr_word_u estat_w;

    // ESTAT code fields live with the exception regs, IS with int ctrl
    always_comb begin
        estat_w.raw = estat_code_rval;
        estat_w.estat.is = estat_is;
    end

    always_comb begin
        case (rnum)
            csr_addr_pkg::CSR_CRMD:   rval = crmd_rval;
            csr_addr_pkg::CSR_PRMD:   rval = prmd_rval;
            csr_addr_pkg::CSR_ECFG:   rval = ecfg_rval;
            csr_addr_pkg::CSR_ESTAT:  rval = estat_w.raw;
            csr_addr_pkg::CSR_ERA:    rval = era_rval;
            csr_addr_pkg::CSR_EENTRY: rval = eentry_rval;
            csr_addr_pkg::CSR_SAVE0:  rval = save_rval[0];
            csr_addr_pkg::CSR_SAVE1:  rval = save_rval[1];
            csr_addr_pkg::CSR_SAVE2:  rval = save_rval[2];
            csr_addr_pkg::CSR_SAVE3:  rval = save_rval[3];
            csr_addr_pkg::CSR_TCFG:   rval = tcfg_rval;
            csr_addr_pkg::CSR_TVAL:   rval = tval_rval;
            // TICLR is write-only and reads as zero
            default:                  rval = '0;
        endcase
    end

endmodule

// ==== src/csr_int_ctrl.sv ====
`timescale 1ns/1ps

module csr_int_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    csr_write_if.sink                           wr,
    input  logic                                crmd_ie,
    input  logic                                timer_expire,
    output csr_field_pkg::word_t                ecfg_rval,
    output logic [csr_field_pkg::IS_BITS-1:0]   estat_is,
    output logic                                has_int
);

    csr_field_pkg::csr_word_u wm;
    csr_field_pkg::csr_word_u wv;

    logic [csr_field_pkg::IS_BITS-1:0]   ecfg_lie;
    logic [csr_field_pkg::SOFT_IRQS-1:0] soft_is;
    logic                                timer_is;

    logic ecfg_we;
    logic estat_we;
    logic ticlr_we;

    assign wm.raw = wr.mask;
    assign wv.raw = wr.wval;

    assign ecfg_we  = wr.we && wr.num == csr_addr_pkg::CSR_ECFG;
    assign estat_we = wr.we && wr.num == csr_addr_pkg::CSR_ESTAT;
    assign ticlr_we = wr.we && wr.num == csr_addr_pkg::CSR_TICLR;

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie <= '0;
        end else if (ecfg_we) begin
            ecfg_lie <= wm.ecfg.lie & wv.ecfg.lie | ~wm.ecfg.lie & ecfg_lie;
        end
    end

    // only the software lines of IS are writable
    always_ff @(posedge clk) begin
        if (rst) begin
            soft_is <= '0;
        end else if (estat_we) begin
            soft_is <= wm.estat.is[csr_field_pkg::SOFT_IRQS-1:0]
                     & wv.estat.is[csr_field_pkg::SOFT_IRQS-1:0]
                     | ~wm.estat.is[csr_field_pkg::SOFT_IRQS-1:0] & soft_is;
        end
    end

    // expiry beats a TICLR clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_is <= 1'b0;
        end else if (timer_expire) begin
            timer_is <= 1'b1;
        end else if (ticlr_we && wm.raw[0] && wv.raw[0]) begin
            timer_is <= 1'b0;
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[csr_field_pkg::SOFT_IRQS-1:0] = soft_is;
        estat_is[csr_field_pkg::TIMER_IRQ] = timer_is;
    end

    assign ecfg_rval = csr_field_pkg::ecfg_t'{rsv: '0, lie: ecfg_lie};
    assign has_int   = crmd_ie & (|(estat_is & ecfg_lie));

endmodule

// ==== src/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer (
    input  logic                  clk,
    input  logic                  rst,
    csr_write_if.sink             wr,
    output csr_field_pkg::word_t  tcfg_rval,
    output csr_field_pkg::word_t  tval_rval,
    output logic                  timer_expire
);

    logic                                                tcfg_en;
    logic                                                tcfg_periodic;
    logic [csr_field_pkg::XLEN-csr_field_pkg::TIMER_SHIFT-1:0] tcfg_initval;
    csr_field_pkg::word_t                                timer_cnt;

    csr_field_pkg::csr_word_u tcfg_nxt;
    logic                     tcfg_we;

    assign tcfg_we = wr.we && wr.num == csr_addr_pkg::CSR_TCFG;

    assign tcfg_rval = csr_field_pkg::tcfg_t'{
        initval:  tcfg_initval,
        periodic: tcfg_periodic,
        en:       tcfg_en
    };

    // TCFG as it will look after this cycle's write
    assign tcfg_nxt.raw = wr.mask & wr.wval | ~wr.mask & tcfg_rval;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_nxt.tcfg.en;
            tcfg_periodic <= tcfg_nxt.tcfg.periodic;
            tcfg_initval  <= tcfg_nxt.tcfg.initval;
        end
    end

    // one-shot mode falls through zero to the idle value and stays there
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cnt <= csr_field_pkg::TIMER_IDLE;
        end else if (tcfg_we && tcfg_nxt.tcfg.en) begin
            timer_cnt <= {tcfg_nxt.tcfg.initval, {csr_field_pkg::TIMER_SHIFT{1'b0}}};
        end else if (tcfg_en && timer_cnt != csr_field_pkg::TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, {csr_field_pkg::TIMER_SHIFT{1'b0}}};
            end else begin
                timer_cnt <= timer_cnt - 1;
            end
        end
    end

    assign tval_rval    = timer_cnt;
    assign timer_expire = tcfg_en && timer_cnt == '0;

endmodule

// ==== src/csr_exc_regs.sv ====
`timescale 1ns/1ps

module csr_exc_regs (
    input  logic                         clk,
    input  logic                         rst,
    csr_write_if.sink                    wr,
    input  logic                         wb_exc,
    input  csr_addr_pkg::ecode_t         wb_ecode,
    input  csr_addr_pkg::esubcode_t      wb_esubcode,
    input  csr_field_pkg::word_t         wb_pc,
    input  logic                         ertn_flush,
    output logic                         crmd_ie,
    output csr_field_pkg::word_t         crmd_rval,
    output csr_field_pkg::word_t         prmd_rval,
    output csr_field_pkg::word_t         era_rval,
    output csr_field_pkg::word_t         eentry_rval,
    output csr_field_pkg::word_t         estat_code_rval,
    output csr_field_pkg::word_t [3:0]   save_rval
);

    csr_field_pkg::csr_word_u wm;
    csr_field_pkg::csr_word_u wv;

    csr_field_pkg::plv_t      crmd_plv;
    csr_field_pkg::plv_t      prmd_pplv;
    logic                     prmd_pie;
    csr_field_pkg::word_t     era_pc;
    logic [csr_field_pkg::XLEN-1:csr_field_pkg::ENTRY_ALIGN] eentry_va;
    csr_addr_pkg::ecode_t     estat_ecode;
    csr_addr_pkg::esubcode_t  estat_esubcode;

    logic crmd_we;
    logic prmd_we;
    logic era_we;
    logic eentry_we;

    assign wm.raw = wr.mask;
    assign wv.raw = wr.wval;

    assign crmd_we   = wr.we && wr.num == csr_addr_pkg::CSR_CRMD;
    assign prmd_we   = wr.we && wr.num == csr_addr_pkg::CSR_PRMD;
    assign era_we    = wr.we && wr.num == csr_addr_pkg::CSR_ERA;
    assign eentry_we = wr.we && wr.num == csr_addr_pkg::CSR_EENTRY;

    // exception entry wins over ertn, ertn over csr writes
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_exc) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv <= wm.crmd.plv & wv.crmd.plv | ~wm.crmd.plv & crmd_plv;
            crmd_ie  <= wm.crmd.ie & wv.crmd.ie | ~wm.crmd.ie & crmd_ie;
        end
    end

    // previous mode, restored by ertn
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_exc) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= wm.prmd.pplv & wv.prmd.pplv | ~wm.prmd.pplv & prmd_pplv;
            prmd_pie  <= wm.prmd.pie & wv.prmd.pie | ~wm.prmd.pie & prmd_pie;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era_pc <= '0;
        end else if (wb_exc) begin
            era_pc <= wb_pc;
        end else if (era_we) begin
            era_pc <= wm.raw & wv.raw | ~wm.raw & era_pc;
        end
    end

    // handler base, low bits always read zero
    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_va <= '0;
        end else if (eentry_we) begin
            eentry_va <= wm.raw[csr_field_pkg::XLEN-1:csr_field_pkg::ENTRY_ALIGN]
                       & wv.raw[csr_field_pkg::XLEN-1:csr_field_pkg::ENTRY_ALIGN]
                       | ~wm.raw[csr_field_pkg::XLEN-1:csr_field_pkg::ENTRY_ALIGN]
                       & eentry_va;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_exc) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr.we && wr.num == csr_addr_pkg::CSR_SAVE0 + csr_addr_pkg::csr_num_t'(i)) begin
                save_rval[i] <= wm.raw & wv.raw | ~wm.raw & save_rval[i];
            end
        end
    end

    assign crmd_rval = csr_field_pkg::crmd_t'{rsv: '0, ie: crmd_ie, plv: crmd_plv};
    assign prmd_rval = csr_field_pkg::prmd_t'{rsv: '0, pie: prmd_pie, pplv: prmd_pplv};
    assign era_rval  = era_pc;
    assign eentry_rval = {eentry_va, {csr_field_pkg::ENTRY_ALIGN{1'b0}}};

    // IS bits are merged in by the read mux
    assign estat_code_rval = csr_field_pkg::estat_t'{
        rsv_hi:   1'b0,
        esubcode: estat_esubcode,
        ecode:    estat_ecode,
        rsv_lo:   '0,
        is:       '0
    };

endmodule

// ==== src/csr_write_if.sv ====
`timescale 1ns/1ps

interface csr_write_if;

    logic                     we;
    csr_addr_pkg::csr_num_t   num;
    csr_field_pkg::word_t     mask;
    csr_field_pkg::word_t     wval;

    // driven once at the top, decoded by each register group
    modport src (
        output we, num, mask, wval
    );

    modport sink (
        input we, num, mask, wval
    );

endinterface

// ==== src/csr_field_pkg.sv ====
package csr_field_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [1:0]      plv_t;

    // interrupt lines in ESTAT.IS and ECFG.LIE
    localparam int IS_BITS   = 13;
    localparam int TIMER_IRQ = 11;
    localparam int SOFT_IRQS = 2;

    // TVAL parks here after reset and after a one-shot expiry
    localparam word_t TIMER_IDLE = '1;

    localparam int ENTRY_ALIGN = 6;
    localparam int TIMER_SHIFT = 2;

    typedef struct packed {
        logic [XLEN-4:0] rsv;
        logic            ie;
        plv_t            plv;
    } crmd_t;

    typedef struct packed {
        logic [XLEN-4:0] rsv;
        logic            pie;
        plv_t            pplv;
    } prmd_t;

    typedef struct packed {
        logic [XLEN-IS_BITS-1:0] rsv;
        logic [IS_BITS-1:0]      lie;
    } ecfg_t;

    typedef struct packed {
        logic                    rsv_hi;
        csr_addr_pkg::esubcode_t esubcode;
        csr_addr_pkg::ecode_t    ecode;
        logic [2:0]              rsv_lo;
        logic [IS_BITS-1:0]      is;
    } estat_t;

    typedef struct packed {
        logic [XLEN-TIMER_SHIFT-1:0] initval;
        logic                        periodic;
        logic                        en;
    } tcfg_t;

    // one register word seen through the layout of its target
    typedef union packed {
        word_t  raw;
        crmd_t  crmd;
        prmd_t  prmd;
        ecfg_t  ecfg;
        estat_t estat;
        tcfg_t  tcfg;
    } csr_word_u;

endpackage

// ==== src/csr_addr_pkg.sv ====
package csr_addr_pkg;

    // CSR index as carried by the csrrd/csrwr/csrxchg encoding
    typedef logic [13:0] csr_num_t;

    // exception state
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_EENTRY = 14'h00c;

    // scratch registers for the exception handler
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;

    // constant timer
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // cause fields captured into ESTAT on exception entry
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

endpackage
